/* hw/cache_pkg.sv */
//--------------------------------------------------------------------
// Shared cache definitions: geometry constants, opcode enum,
// cache and memory message structs, control and status structs
//--------------------------------------------------------------------

package cache_pkg;

  //------------------------------------------------------------------
  // Geometry
  //------------------------------------------------------------------

  localparam int LINE_BITS      = 128;                   // Cache line and memory data width
  localparam int ADDR_BITS      = 32;                    // Byte address width
  localparam int WORD_BITS      = 32;                    // Access width of the cache port
  localparam int OPAQUE_BITS    = 8;                     // Tag passed back unchanged to requester
  localparam int LINE_BYTES     = LINE_BITS / 8;         // 16 bytes per line
  localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS; // 4 words per line
  localparam int OFFSET_BITS    = $clog2(LINE_BYTES);    // Byte offset within a line

  //------------------------------------------------------------------
  // Opcodes
  //------------------------------------------------------------------

  typedef enum logic [1:0] {
    MEM_INIT  = 2'd0,  // Fill cache word, no memory traffic
    MEM_READ  = 2'd1,
    MEM_WRITE = 2'd2
  } mem_op_t;

  //------------------------------------------------------------------
  // Messages
  //------------------------------------------------------------------

  typedef struct packed {
    mem_op_t                op;
    logic [OPAQUE_BITS-1:0] opaque;
    logic [ADDR_BITS-1:0]   addr;
    logic [WORD_BITS-1:0]   data;
  } cache_req_t;   // 74 bits

  typedef struct packed {
    mem_op_t                op;
    logic [OPAQUE_BITS-1:0] opaque;
    logic [WORD_BITS-1:0]   data;    // Zero for init and write
  } cache_resp_t;  // 42 bits

  typedef struct packed {
    mem_op_t              op;        // Read or write only
    logic [ADDR_BITS-1:0] addr;      // Line aligned
    logic [LINE_BITS-1:0] data;
  } mem_req_t;     // 162 bits

  typedef struct packed {
    mem_op_t              op;
    logic [LINE_BITS-1:0] data;
  } mem_resp_t;    // 130 bits

  //------------------------------------------------------------------
  // Controller <-> datapath
  //------------------------------------------------------------------

  typedef struct packed {
    logic req_en;            // Load request register
    logic memresp_en;        // Load refill line register
    logic tag_array_ren;     // Read tag, valid and dirty at index
    logic tag_array_wen;     // Write tag, set valid, dirty from set_dirty
    logic data_array_wen;    // Write data array
    logic refill_sel;        // Line data from memory, not the request word
    logic word_merge;        // Write only the addressed word
    logic read_data_reg_en;  // Capture read word for the response
    logic read_tag_reg_en;   // Capture victim tag
    logic memreq_evict;      // Victim address and write opcode on memreq
    logic set_dirty;         // Dirty value written with the tag
  } cache_ctrl_t;

  typedef struct packed {
    mem_op_t req_op;         // Opcode of the registered request
    logic    tag_match;      // Valid and tag equal
    logic    victim_dirty;   // Indexed line valid and dirty
  } cache_status_t;

endpackage

/* hw/cache_ctrl.sv */
//--------------------------------------------------------------------
// Blocking cache controller FSM: tag check, data access,
// write-back eviction, refill and response handshake
//--------------------------------------------------------------------

module cache_ctrl import cache_pkg::*; (
  input  logic          clk,
  input  logic          reset,

  input  logic          cachereq_val,
  output logic          cachereq_rdy,

  output logic          cacheresp_val,
  input  logic          cacheresp_rdy,

  output logic          memreq_val,
  input  logic          memreq_rdy,

  input  logic          memresp_val,
  output logic          memresp_rdy,

  input  cache_status_t status,
  output cache_ctrl_t   ctrl
);

  //------------------------------------------------------------------
  // State register
  //------------------------------------------------------------------

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    INIT_DATA_ACCESS,
    READ_DATA_ACCESS,
    WRITE_DATA_ACCESS,
    EVICT_REQUEST,
    EVICT_WAIT,
    REFILL_REQUEST,
    REFILL_WAIT,
    REFILL_UPDATE,
    WAIT
  } state_t;

  state_t state_reg;
  state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= IDLE;
    end else begin
      state_reg <= state_next;
    end
  end

  //------------------------------------------------------------------
  // Next state
  //------------------------------------------------------------------

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      IDLE:              if (cachereq_val) state_next = TAG_CHECK;
      TAG_CHECK: begin
        if (status.req_op == MEM_INIT) begin
          state_next = INIT_DATA_ACCESS;          // Init never misses
        end else if (status.tag_match) begin
          state_next = (status.req_op == MEM_WRITE) ? WRITE_DATA_ACCESS : READ_DATA_ACCESS;
        end else if (status.victim_dirty) begin
          state_next = EVICT_REQUEST;             // Write back first
        end else begin
          state_next = REFILL_REQUEST;
        end
      end
      INIT_DATA_ACCESS:  state_next = WAIT;
      READ_DATA_ACCESS:  state_next = WAIT;
      WRITE_DATA_ACCESS: state_next = WAIT;
      EVICT_REQUEST:     if (memreq_rdy) state_next = EVICT_WAIT;
      EVICT_WAIT:        if (memresp_val) state_next = REFILL_REQUEST;
      REFILL_REQUEST:    if (memreq_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT:       if (memresp_val) state_next = REFILL_UPDATE;
      REFILL_UPDATE: begin
        // Line now present, finish the original access
        state_next = (status.req_op == MEM_WRITE) ? WRITE_DATA_ACCESS : READ_DATA_ACCESS;
      end
      WAIT:              if (cacheresp_rdy) state_next = IDLE;
      default:           state_next = IDLE;
    endcase
  end

  //------------------------------------------------------------------
  // Output table
  //------------------------------------------------------------------

  typedef struct packed {
    logic        cachereq_rdy;
    logic        cacheresp_val;
    logic        memreq_val;
    logic        memresp_rdy;
    cache_ctrl_t ctrl;
  } cs_t;

  cs_t cs;

  function automatic cs_t cs_row(
    input logic rq_rdy, input logic rs_val, input logic mq_val, input logic ms_rdy,
    input logic req,    input logic mrsp,   input logic tren,   input logic twen,
    input logic dwen,   input logic rsel,   input logic merge,  input logic rden,
    input logic tgen,   input logic evict,  input logic dirty
  );
    cs_t row;
    row.cachereq_rdy          = rq_rdy;
    row.cacheresp_val         = rs_val;
    row.memreq_val            = mq_val;
    row.memresp_rdy           = ms_rdy;
    row.ctrl.req_en           = req;
    row.ctrl.memresp_en       = mrsp;
    row.ctrl.tag_array_ren    = tren;
    row.ctrl.tag_array_wen    = twen;
    row.ctrl.data_array_wen   = dwen;
    row.ctrl.refill_sel       = rsel;
    row.ctrl.word_merge       = merge;
    row.ctrl.read_data_reg_en = rden;
    row.ctrl.read_tag_reg_en  = tgen;
    row.ctrl.memreq_evict     = evict;
    row.ctrl.set_dirty        = dirty;
    return row;
  endfunction

  always_comb begin
    case (state_reg)
      //                        rq rs mq ms  req           mr tr tw dw rs wm rd tg ev dy
      IDLE:              cs = cs_row(1, 0, 0, 0, cachereq_val, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
      TAG_CHECK:         cs = cs_row(0, 0, 0, 0, 0,            0, 1, 0, 0, 0, 0, 0, 1, 0, 0);
      INIT_DATA_ACCESS:  cs = cs_row(0, 0, 0, 0, 0,            0, 0, 1, 1, 0, 1, 0, 0, 0, 0);
      READ_DATA_ACCESS:  cs = cs_row(0, 0, 0, 0, 0,            0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
      WRITE_DATA_ACCESS: cs = cs_row(0, 0, 0, 0, 0,            0, 0, 1, 1, 0, 1, 0, 0, 0, 1);
      EVICT_REQUEST:     cs = cs_row(0, 0, 1, 0, 0,            0, 0, 0, 0, 0, 0, 0, 0, 1, 0);
      EVICT_WAIT:        cs = cs_row(0, 0, 0, 1, 0,            0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
      REFILL_REQUEST:    cs = cs_row(0, 0, 1, 0, 0,            0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
      REFILL_WAIT:       cs = cs_row(0, 0, 0, 1, 0,            1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
      REFILL_UPDATE:     cs = cs_row(0, 0, 0, 0, 0,            0, 0, 1, 1, 1, 0, 0, 0, 0, 0);
      WAIT:              cs = cs_row(0, 1, 0, 0, 0,            0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
      default:           cs = cs_row(0, 0, 0, 0, 0,            0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    endcase
  end

  // Unpack the selected row
  assign cachereq_rdy  = cs.cachereq_rdy;
  assign cacheresp_val = cs.cacheresp_val;
  assign memreq_val    = cs.memreq_val;
  assign memresp_rdy   = cs.memresp_rdy;
  assign ctrl          = cs.ctrl;

endmodule

/* hw/cache_dpath.sv */
//--------------------------------------------------------------------
// Cache datapath: request and refill registers, tag/valid/dirty
// arrays, data array, word merge, read select, message assembly
//--------------------------------------------------------------------

module cache_dpath import cache_pkg::*; #(
  parameter int cache_bytes = 256   // Total capacity in bytes
) (
  input  logic          clk,
  input  logic          reset,

  input  cache_req_t    cachereq,
  output cache_resp_t   cacheresp,

  output mem_req_t      memreq,
  input  mem_resp_t     memresp,

  input  cache_ctrl_t   ctrl,
  output cache_status_t status
);

  localparam int nlines    = cache_bytes / LINE_BYTES;           // Direct mapped, one way
  localparam int idx_bits  = $clog2(nlines);
  localparam int woff_bits = $clog2(WORDS_PER_LINE);             // Word within line
  localparam int byte_bits = OFFSET_BITS - woff_bits;            // Byte within word
  localparam int tag_bits  = ADDR_BITS - idx_bits - OFFSET_BITS;

  //------------------------------------------------------------------
  // Request and refill registers
  //------------------------------------------------------------------

  cache_req_t           req_reg;
  logic [LINE_BITS-1:0] refill_line;   // Line returned by memory
  logic [tag_bits-1:0]  victim_tag;    // Tag of the line being replaced
  logic [WORD_BITS-1:0] read_data;     // Word held for the response

  logic [tag_bits-1:0]  req_tag;
  logic [idx_bits-1:0]  req_idx;
  logic [woff_bits-1:0] req_woff;

  assign req_tag  = req_reg.addr[ADDR_BITS-1 -: tag_bits];
  assign req_idx  = req_reg.addr[OFFSET_BITS +: idx_bits];
  assign req_woff = req_reg.addr[byte_bits +: woff_bits];

  //------------------------------------------------------------------
  // Arrays
  //------------------------------------------------------------------

  logic [tag_bits-1:0]  tag_array  [nlines];
  logic [LINE_BITS-1:0] data_array [nlines];
  logic [nlines-1:0]    valid_bits;
  logic [nlines-1:0]    dirty_bits;

  logic [LINE_BITS-1:0]      rd_line;
  logic [WORD_BITS-1:0]      rd_word;
  logic [LINE_BITS-1:0]      line_wdata;
  logic [WORDS_PER_LINE-1:0] word_en;
  logic                      rd_valid;
  logic                      rd_dirty;

  assign rd_line = data_array[req_idx];
  assign rd_word = rd_line[req_woff*WORD_BITS +: WORD_BITS];

  // Refill writes the whole line, init and write only one word
  assign line_wdata = ctrl.refill_sel ? refill_line : {WORDS_PER_LINE{req_reg.data}};
  assign word_en    = ctrl.word_merge ? (WORDS_PER_LINE'(1) << req_woff) : '1;

  always_ff @(posedge clk) begin
    if (ctrl.req_en) req_reg <= cachereq;
    if (ctrl.memresp_en) refill_line <= memresp.data;
    if (ctrl.read_tag_reg_en) victim_tag <= tag_array[req_idx];
    if (ctrl.read_data_reg_en) read_data <= rd_word;
  end

  // Valid and dirty bits, cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (ctrl.tag_array_wen) begin
      valid_bits[req_idx] <= 1'b1;
      dirty_bits[req_idx] <= ctrl.set_dirty;  // Clean after refill or init
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.tag_array_wen) tag_array[req_idx] <= req_tag;
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      if (ctrl.data_array_wen && word_en[i]) begin
        data_array[req_idx][i*WORD_BITS +: WORD_BITS] <= line_wdata[i*WORD_BITS +: WORD_BITS];
      end
    end
  end

  //------------------------------------------------------------------
  // Status to controller
  //------------------------------------------------------------------

  assign rd_valid = ctrl.tag_array_ren && valid_bits[req_idx];
  assign rd_dirty = ctrl.tag_array_ren && dirty_bits[req_idx];

  assign status.req_op       = req_reg.op;
  assign status.tag_match    = rd_valid && (tag_array[req_idx] == req_tag);
  assign status.victim_dirty = rd_valid && rd_dirty;

  //------------------------------------------------------------------
  // Outgoing messages
  //------------------------------------------------------------------

  // Eviction writes the old line back to its own address
  assign memreq.op   = ctrl.memreq_evict ? MEM_WRITE : MEM_READ;
  assign memreq.addr = {(ctrl.memreq_evict ? victim_tag : req_tag), req_idx,
                        {OFFSET_BITS{1'b0}}};
  assign memreq.data = rd_line;

  assign cacheresp.op     = req_reg.op;
  assign cacheresp.opaque = req_reg.opaque;
  assign cacheresp.data   = (req_reg.op == MEM_READ) ? read_data : '0;  // Only reads carry data

endmodule

/* hw/main_mem.sv */
//--------------------------------------------------------------------
// Backing memory model, line wide, fixed response latency
//--------------------------------------------------------------------

module main_mem import cache_pkg::*; #(
  parameter int mem_latency = 4,    // Cycles from accept to response
  parameter int mem_lines   = 256   // Number of lines stored
) (
  input  logic      clk,
  input  logic      reset,

  input  mem_req_t  memreq,
  input  logic      memreq_val,
  output logic      memreq_rdy,

  output mem_resp_t memresp,
  output logic      memresp_val,
  input  logic      memresp_rdy
);

  localparam int line_idx_bits = $clog2(mem_lines);
  localparam int cnt_bits      = $clog2(mem_latency + 2);

  logic [LINE_BITS-1:0]     mem [mem_lines];
  logic [line_idx_bits-1:0] req_line;      // Wraps at mem_lines
  logic                     pending;       // One access in flight
  logic [cnt_bits-1:0]      count;         // Cycles left until response
  mem_resp_t                resp_reg;
  logic                     req_go;
  logic                     resp_go;

  assign req_line    = memreq.addr[OFFSET_BITS +: line_idx_bits];
  assign memreq_rdy  = !pending;
  assign req_go      = memreq_val && memreq_rdy;
  assign memresp_val = pending && (count == '0);
  assign resp_go     = memresp_val && memresp_rdy;
  assign memresp     = resp_reg;

  //------------------------------------------------------------------
  // Latency timer
  //------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      count   <= '0;
    end else if (req_go) begin
      pending <= 1'b1;
      count   <= cnt_bits'(mem_latency);
    end else if (resp_go) begin
      pending <= 1'b0;
    end else if (pending && (count != '0)) begin
      count <= count - 1'b1;
    end
  end

  // Storage and response payload
  always_ff @(posedge clk) begin
    if (req_go) begin
      resp_reg.op <= memreq.op;
      if (memreq.op == MEM_WRITE) begin
        mem[req_line]  <= memreq.data;   // Write lands on the accepting edge
        resp_reg.data  <= '0;
      end else begin
        resp_reg.data  <= mem[req_line];
      end
    end
  end

endmodule

/* hw/cache_mem_top.sv */
//--------------------------------------------------------------------
// Cache with backing memory: controller, datapath, memory model
//--------------------------------------------------------------------

module cache_mem_top import cache_pkg::*; #(
  parameter int cache_bytes = 256,  // Cache capacity
  parameter int mem_latency = 4,    // Memory response delay
  parameter int mem_lines   = 256   // Memory depth in lines
) (
  input  logic        clk,
  input  logic        reset,

  input  cache_req_t  cachereq,
  input  logic        cachereq_val,
  output logic        cachereq_rdy,

  output cache_resp_t cacheresp,
  output logic        cacheresp_val,
  input  logic        cacheresp_rdy
);

  // Cache <-> memory channels
  mem_req_t      memreq;
  logic          memreq_val;
  logic          memreq_rdy;
  mem_resp_t     memresp;
  logic          memresp_val;
  logic          memresp_rdy;

  // Controller <-> datapath
  cache_ctrl_t   ctrl;
  cache_status_t status;

  cache_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .status        (status),
    .ctrl          (ctrl)
  );

  cache_dpath #(.cache_bytes(cache_bytes)) u_dpath (
    .clk       (clk),
    .reset     (reset),
    .cachereq  (cachereq),
    .cacheresp (cacheresp),
    .memreq    (memreq),
    .memresp   (memresp),
    .ctrl      (ctrl),
    .status    (status)
  );

  main_mem #(.mem_latency(mem_latency), .mem_lines(mem_lines)) u_mem (
    .clk         (clk),
    .reset       (reset),
    .memreq      (memreq),
    .memreq_val  (memreq_val),
    .memreq_rdy  (memreq_rdy),
    .memresp     (memresp),
    .memresp_val (memresp_val),
    .memresp_rdy (memresp_rdy)
  );

endmodule

/* verif/cache_tb.sv */
//--------------------------------------------------------------------
// Cache testbench: trace driven requests, random response
// back-pressure, response checks and summary
//--------------------------------------------------------------------

module cache_tb import cache_pkg::*; ();

  localparam int cache_bytes  = 256;
  localparam int mem_latency  = 4;
  localparam int mem_lines    = 256;
  localparam int max_reqs     = 64;                          // Trace capacity
  localparam int miss_cost    = 2 * (mem_latency + 3) + 6;   // Dirty eviction plus refill
  localparam int req_slack    = 3 + 4;   // Back-pressure and edge alignment per request
  localparam int reset_cycles = 4;
  localparam int margin       = 50;

  logic        clk;
  logic        reset;
  cache_req_t  cachereq;
  logic        cachereq_val;
  logic        cachereq_rdy;
  cache_resp_t cacheresp;
  logic        cacheresp_val;
  logic        cacheresp_rdy;

  // Trace contents, one entry per request
  int          tr_test   [max_reqs];
  logic [1:0]  tr_op     [max_reqs];
  logic [7:0]  tr_opaque [max_reqs];
  logic [31:0] tr_addr   [max_reqs];
  logic [31:0] tr_data   [max_reqs];
  logic [31:0] tr_exp    [max_reqs];   // Expected response data
  int          num_reqs;

  int          total_checks;
  int          total_errors;
  int          group_checks;
  int          group_errors;
  int          cycle_count;
  int          cycle_limit;            // Zero until the trace is loaded
  integer      seed;

  cache_mem_top #(
    .cache_bytes (cache_bytes),
    .mem_latency (mem_latency),
    .mem_lines   (mem_lines)
  ) DUT (
    .clk           (clk),
    .reset         (reset),
    .cachereq      (cachereq),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp     (cacheresp),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // Period 8
  end

  //------------------------------------------------------------------
  // Timeout watchdog
  //------------------------------------------------------------------

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles: a request was not accepted or its response never came",
               cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

  //------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------

  task automatic load_trace(output bit ok);
    int          fd;
    int          n;
    int          t;
    int          op;
    logic [7:0]  opq;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    string       line;
    ok       = 1'b0;
    num_reqs = 0;
    fd = $fopen("verif/cache_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file verif/cache_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin  // Skip comments
          n = $sscanf(line, "%d %h %h %h %h %h", t, op, opq, a, d, e);
          if (n == 6 && num_reqs < max_reqs) begin
            tr_test[num_reqs]   = t;
            tr_op[num_reqs]     = 2'(op);
            tr_opaque[num_reqs] = opq;
            tr_addr[num_reqs]   = a;
            tr_data[num_reqs]   = d;
            tr_exp[num_reqs]    = e;
            num_reqs++;
          end
        end
      end
      $fclose(fd);
      ok = (num_reqs > 0);
      if (!ok) $display("The trace file holds no requests");
    end
  endtask

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    total_checks++;
    group_checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      total_errors++;
      group_errors++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("Error at time %0t: %s", $time, what);
    total_errors++;
    group_errors++;
  endtask

  task automatic report_group(input string label);
    $display("%s: %0d checks, %0d errors, %s", label, group_checks, group_errors,
             (group_errors == 0) ? "ok" : "mismatches seen");
    group_checks = 0;
    group_errors = 0;
  endtask

  // Drive one request at a falling edge and hold it until accepted
  task automatic send_request(input int idx);
    @(negedge clk);
    cachereq.op     = mem_op_t'(tr_op[idx]);
    cachereq.opaque = tr_opaque[idx];
    cachereq.addr   = tr_addr[idx];
    cachereq.data   = tr_data[idx];
    cachereq_val    = 1'b1;
    while (!cachereq_rdy) @(negedge clk);   // rdy sampled mid-cycle
    @(negedge clk);                          // Transfer on the rising edge just passed
    cachereq_val = 1'b0;
  endtask

  // Wait for the response, stall it a random 0 to 3 cycles, then check it
  task automatic collect_response(input int idx);
    int hold;
    hold = $unsigned($random(seed)) % 4;
    while (!cacheresp_val) @(negedge clk);
    repeat (hold) @(negedge clk);
    if (!cacheresp_val) note_failure("cacheresp_val dropped while cacheresp_rdy was low");
    cacheresp_rdy = 1'b1;
    compare_field("cacheresp.op", 32'(tr_op[idx]), 32'(cacheresp.op));
    compare_field("cacheresp.opaque", 32'(tr_opaque[idx]), 32'(cacheresp.opaque));
    compare_field("cacheresp.data", tr_exp[idx], cacheresp.data);
    @(negedge clk);
    cacheresp_rdy = 1'b0;
    if (cacheresp_val) note_failure("a second response followed a single request");
  endtask

  //------------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------------

  initial begin
    bit trace_ok;
    int cur_test;
    seed          = 32'h4f01;
    reset         = 1'b1;
    cachereq      = '0;
    cachereq_val  = 1'b0;
    cacheresp_rdy = 1'b0;
    total_checks  = 0;
    total_errors  = 0;
    group_checks  = 0;
    group_errors  = 0;
    cycle_count   = 0;
    cycle_limit   = 0;

    load_trace(trace_ok);
    if (trace_ok) cycle_limit = num_reqs * (miss_cost + req_slack) + reset_cycles + margin;

    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle state straight out of reset
    compare_field("cachereq_rdy", 32'd1, 32'(cachereq_rdy));
    compare_field("cacheresp_val", 32'd0, 32'(cacheresp_val));
    report_group("Reset");

    if (trace_ok) begin
      cur_test = tr_test[0];
      for (int i = 0; i < num_reqs; i++) begin
        if (tr_test[i] != cur_test) begin
          report_group($sformatf("Test %0d", cur_test));
          cur_test = tr_test[i];
        end
        send_request(i);
        collect_response(i);
      end
      report_group($sformatf("Test %0d", cur_test));
    end

    $display("Summary: %0d requests, %0d checks, %0d errors", num_reqs, total_checks,
             total_errors);
    if (!trace_ok || total_errors != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

/* verif/cache_trace.txt */
// test op opaque addr data expected_data
// op is 0 init, 1 read, 2 write; all fields after test are hex
// Test 1: init then read hits in four lines
1 0 01 00000000 11110000 00000000
1 0 02 00000014 22221111 00000000
1 0 03 00000028 33332222 00000000
1 0 04 0000003c 44443333 00000000
1 1 05 00000000 00000000 11110000
1 1 06 00000014 00000000 22221111
1 1 07 00000028 00000000 33332222
1 1 08 0000003c 00000000 44443333
// Test 2: write hits then reads
2 2 10 00000000 aaaa0001 00000000
2 2 11 00000014 bbbb0002 00000000
2 2 12 00000004 cccc0003 00000000
2 1 13 00000000 00000000 aaaa0001
2 1 14 00000014 00000000 bbbb0002
2 1 15 00000004 00000000 cccc0003
2 1 16 00000028 00000000 33332222
// Test 3: conflicting writes evict dirty lines, read misses refill them
3 2 20 00000100 eeee0005 00000000
3 2 21 00000114 ffff0006 00000000
3 1 22 00000000 00000000 aaaa0001
3 1 23 00000004 00000000 cccc0003
3 1 24 00000014 00000000 bbbb0002
3 1 25 00000100 00000000 eeee0005
3 1 26 00000114 00000000 ffff0006
// Test 4: write miss over a clean line, neighbours come from memory
4 2 30 00000008 dddd0007 00000000
4 1 31 00000008 00000000 dddd0007
4 1 32 00000004 00000000 cccc0003
4 1 33 00000000 00000000 aaaa0001
// Test 5: ping-pong between 0x50 and 0x150 on index 5
5 2 40 00000050 12340001 00000000
5 2 41 00000150 56780001 00000000
5 1 42 00000050 00000000 12340001
5 1 43 00000150 00000000 56780001
5 2 44 00000050 12340002 00000000
5 1 45 00000150 00000000 56780001
5 1 46 00000050 00000000 12340002
5 2 47 00000150 56780002 00000000
5 1 48 00000050 00000000 12340002
5 1 49 00000150 00000000 56780002

/* files.f */
hw/cache_pkg.sv
hw/cache_ctrl.sv
hw/cache_dpath.sv
hw/main_mem.sv
hw/cache_mem_top.sv
verif/cache_tb.sv

/* Makefile */
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= TB PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
